// File: Makefile
SIM      = verilator
FLAGS    = --binary --assert --timing
TOP      = decode_stage_tb
FILELIST = decode_stage.f
RUN_ARGS = +verilator+error+limit+1000
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_bin
	./obj_dir/sim_bin $(RUN_ARGS) | tee $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)
	@! grep -q "Simulation finished: FAIL" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: decode_stage.f
rtl/mips_pkg.sv
rtl/inst_decode.sv
rtl/hazard_unit.sv
rtl/reg_file.sv
rtl/id_ex_reg.sv
rtl/decode_stage.sv
dv/decode_stage_chk.sv
dv/decode_stage_tb.sv

// File: dv/decode_stage_chk.sv
`default_nettype none

module decode_stage_chk import mips_pkg::*; (
  input wire logic      clock,
  input wire logic      arst_n,
  input wire word_t     pc,
  input wire word_t     inst_word,
  input wire reg_addr_t ex_mem_dest,
  input wire logic      ex_mem_dest_valid,
  input wire logic      wb_we,
  input wire reg_addr_t wb_addr,
  input wire word_t     wb_data,
  input wire id_ex_t    id_ex,
  input wire logic      stall
);
  timeunit 1ns;
  timeprecision 100ps;

  int        err_cnt = 0;
  word_t     shadow [32];
  dec_ctrl_t exp_ctrl;
  fwd_t      exp_a_fwd;
  fwd_t      exp_b_fwd;
  logic      exp_stall;
  word_t     exp_rd1;
  word_t     exp_rd2;

  function automatic dec_ctrl_t model(word_t w);
    dec_ctrl_t  c;
    logic [5:0] op;
    logic [5:0] fn;
    op = w[31:26];
    fn = w[5:0];
    c = '0;
    c.a_reg = w[25:21];
    c.b_reg = w[20:16];
    c.dest_reg = w[20:16];
    c.imm = {16'b0, w[15:0]};
    c.alu_op = OP_PASS_A;
    c.res_sel = RES_ALU;
    c.ls_op = LS_WORD;
    if (op == OPC_SPECIAL) begin
      c.dest_reg = w[15:11];
      c.shamt = w[10:6];
      {c.a_valid, c.b_valid, c.dest_valid, c.alu_inst} = 4'b1111;
      case (fn)
        FN_SLL, FN_SLLV: c.alu_op = OP_SLL;
        FN_SRL, FN_SRLV: c.alu_op = OP_SRL;
        FN_SRA, FN_SRAV: c.alu_op = OP_SRA;
        FN_ADD, FN_ADDU: c.alu_op = OP_ADD;
        FN_SUB, FN_SUBU: c.alu_op = OP_SUB;
        FN_AND: c.alu_op = OP_AND;
        FN_OR: c.alu_op = OP_OR;
        FN_XOR: c.alu_op = OP_XOR;
        FN_NOR: c.alu_op = OP_NOR;
        FN_SLT, FN_SLTU: begin
          c.alu_op = OP_SUB;
          c.res_sel = RES_SET;
          c.alu_set_u = fn[0];
        end
        FN_JR, FN_JALR: begin
          {c.b_valid, c.alu_inst, c.jmp_inst} = 3'b001;
          c.dest_valid = fn[0];  // only jalr links
        end
        default: begin
          {c.a_valid, c.b_valid, c.dest_valid, c.alu_inst, c.illegal} = 5'b00001;
        end
      endcase
      if (fn == FN_SLL || fn == FN_SRL || fn == FN_SRA) c.a_valid = 1'b0;
    end else begin
      c.imm_valid = 1'b1;
      c.dest_valid = 1'b1;
      c.a_valid = (op != OPC_LUI);
      case (op)
        OPC_ADDI, OPC_ADDIU: c.alu_op = OP_ADD;
        OPC_SLTI, OPC_SLTIU: begin
          c.alu_op = OP_SUB;
          c.res_sel = RES_SET;
          c.alu_set_u = (op == OPC_SLTIU);
        end
        OPC_ANDI: c.alu_op = OP_AND;
        OPC_ORI: c.alu_op = OP_OR;
        OPC_XORI: c.alu_op = OP_XOR;
        OPC_LUI: c.alu_op = OP_LUI;
        OPC_LB, OPC_LH, OPC_LW, OPC_LBU, OPC_LHU,
        OPC_SB, OPC_SH, OPC_SW: c.alu_op = OP_ADD;
        default: begin
          {c.a_valid, c.dest_valid, c.imm_valid, c.illegal} = 4'b0001;
        end
      endcase
      c.alu_inst = !c.illegal && op[5:3] == 3'b001;
      if (op[5:3] == 3'b100) begin  // loads
        c.load_inst = 1'b1;
        c.ls_sext = !op[2] && op[1:0] != 2'b11;  // signed sub-word loads
        c.ls_op = (op[1:0] == 2'b11) ? LS_WORD : op[0] ? LS_HALF : LS_BYTE;
      end
      if (op[5:3] == 3'b101) begin  // stores
        {c.store_inst, c.b_valid, c.b_need_late, c.dest_valid} = 4'b1110;
        c.ls_op = (op[1:0] == 2'b11) ? LS_WORD : op[0] ? LS_HALF : LS_BYTE;
      end
      if (c.alu_op != OP_LUI && op != OPC_ANDI && op != OPC_ORI && op != OPC_XORI && !c.illegal)
        c.imm = {{16{w[15]}}, w[15:0]};
    end
    return c;
  endfunction

  function automatic word_t read_model(reg_addr_t a);
    if (a == '0) return '0;
    if (wb_we && wb_addr == a) return wb_data;
    return shadow[a];
  endfunction

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) shadow[i] <= '0;
    end else if (wb_we && wb_addr != '0) begin
      shadow[wb_addr] <= wb_data;
    end
  end

  always_comb begin
    logic ex_a;
    logic ex_b;
    logic mem_a;
    logic mem_b;
    exp_ctrl = model(inst_word);
    ex_a = exp_ctrl.a_valid && id_ex.ctrl.dest_valid && exp_ctrl.a_reg == id_ex.ctrl.dest_reg;
    ex_b = exp_ctrl.b_valid && id_ex.ctrl.dest_valid && exp_ctrl.b_reg == id_ex.ctrl.dest_reg;
    mem_a = exp_ctrl.a_valid && ex_mem_dest_valid && exp_ctrl.a_reg == ex_mem_dest;
    mem_b = exp_ctrl.b_valid && ex_mem_dest_valid && exp_ctrl.b_reg == ex_mem_dest;
    exp_a_fwd = ex_a ? FWD_EXMEM : mem_a ? FWD_MEMWB : FWD_NONE;
    exp_b_fwd = ex_b ? (id_ex.ctrl.load_inst ? FWD_MEMWB_LATE : FWD_EXMEM) :
                mem_b ? FWD_MEMWB : FWD_NONE;
    exp_stall = id_ex.ctrl.load_inst && (ex_a || (ex_b && !exp_ctrl.b_need_late));
    exp_rd1 = read_model(inst_word[25:21]);
    exp_rd2 = read_model(inst_word[20:16]);
  end

  ctrl_ok: assert property (@(posedge clock) disable iff (!arst_n)
    $past(arst_n) && !$past(stall) |-> id_ex.ctrl == $past(exp_ctrl) && id_ex.pc == $past(pc))
    else begin
      err_cnt++;
      $error("Error at %0t: id_ex.ctrl expected %h got %h", $time, $past(exp_ctrl), id_ex.ctrl);
    end

  fwd_ok: assert property (@(posedge clock) disable iff (!arst_n)
    $past(arst_n) && !$past(stall) |->
      id_ex.a_fwd == $past(exp_a_fwd) && id_ex.b_fwd == $past(exp_b_fwd))
    else begin
      err_cnt++;
      $error("Error at %0t: id_ex.a_fwd/b_fwd expected %0d/%0d got %0d/%0d", $time,
             $past(exp_a_fwd), $past(exp_b_fwd), id_ex.a_fwd, id_ex.b_fwd);
    end

  data_ok: assert property (@(posedge clock) disable iff (!arst_n)
    $past(arst_n) && !$past(stall) |->
      id_ex.a_data == $past(exp_rd1) && id_ex.b_data == $past(exp_rd2))
    else begin
      err_cnt++;
      $error("Error at %0t: id_ex.a_data/b_data expected %h/%h got %h/%h", $time,
             $past(exp_rd1), $past(exp_rd2), id_ex.a_data, id_ex.b_data);
    end

  stall_ok: assert property (@(posedge clock) disable iff (!arst_n) stall == exp_stall)
    else begin
      err_cnt++;
      $error("Error at %0t: stall expected %b got %b", $time, exp_stall, stall);
    end

  bubble_ok: assert property (@(posedge clock) disable iff (!arst_n)
    $past(stall) |-> !stall && id_ex.a_fwd == FWD_NONE && id_ex.b_fwd == FWD_NONE &&
      {id_ex.ctrl.a_valid, id_ex.ctrl.b_valid, id_ex.ctrl.b_need_late, id_ex.ctrl.dest_valid,
       id_ex.ctrl.imm_valid, id_ex.ctrl.alu_inst, id_ex.ctrl.load_inst,
       id_ex.ctrl.store_inst, id_ex.ctrl.jmp_inst, id_ex.ctrl.illegal} == '0)
    else begin
      err_cnt++;
      $error("load-use stall did not give a one-cycle bubble at %0t", $time);
    end

endmodule

`default_nettype wire

// File: dv/decode_stage_tb.sv
`default_nettype none

module decode_stage_tb import mips_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  logic      clock;
  logic      arst_n;
  word_t     pc;
  word_t     inst_word;
  reg_addr_t ex_mem_dest;
  logic      ex_mem_dest_valid;
  logic      wb_we;
  reg_addr_t wb_addr;
  word_t     wb_data;
  id_ex_t    id_ex;
  logic      stall;

  logic [31:0] lfsr = 32'h5a0c_3269;
  int          fails = 0;
  int          mark;

  decode_stage UUT (.*);

  bind decode_stage decode_stage_chk u_chk (.*);

  always #4 clock = !clock;

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // taps 32,22,2,1
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic word_t r_word(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                   shamt_t sa, logic [5:0] fn);
    return {OPC_SPECIAL, rs, rt, rd, sa, fn};
  endfunction

  function automatic word_t i_word(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                   logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // drive one word, hold it while stalled, return after it is captured
  task automatic issue(word_t w);
    int n;
    n = 0;
    inst_word <= w;
    pc <= pc + 32'd4;
    @(negedge clock);
    while (stall) begin
      n++;
      if (n > 10) begin
        $display("stall stayed high for too long at %0t", $time);
        $display("Simulation finished: FAIL");
        $finish;
      end
      @(negedge clock);
    end
    @(posedge clock);
  endtask

  task automatic random_r(logic [5:0] fn);
    issue(r_word(reg_addr_t'(take_bits(5)), reg_addr_t'(take_bits(5)),
                 reg_addr_t'(take_bits(5)), shamt_t'(take_bits(5)), fn));
  endtask

  task automatic random_i(logic [5:0] op);
    issue(i_word(op, reg_addr_t'(take_bits(5)), reg_addr_t'(take_bits(5)),
                 16'(take_bits(16))));
  endtask

  task automatic report(string name);
    repeat (2) issue('0);  // let the last checks fire
    $display("test %s: %0d failures", name, UUT.u_chk.err_cnt - mark);
    mark = UUT.u_chk.err_cnt;
  endtask

  initial begin
    logic [5:0] fns [19] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_JR,
      FN_JALR, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT,
      FN_SLTU, 6'h3f};
    logic [5:0] ops [10] = '{OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU, OPC_ANDI, OPC_ORI,
      OPC_XORI, OPC_LUI, 6'h3e, 6'h01};
    logic [5:0] ls_ops [8] = '{OPC_LB, OPC_LH, OPC_LW, OPC_LBU, OPC_LHU, OPC_SB, OPC_SH,
      OPC_SW};
    clock = 1'b0;
    arst_n = 1'b0;
    pc = '0;
    inst_word = '0;
    ex_mem_dest = '0;
    ex_mem_dest_valid = 1'b0;
    wb_we = 1'b0;
    wb_addr = '0;
    wb_data = '0;
    mark = 0;
    repeat (3) @(posedge clock);
    arst_n <= 1'b1;
    @(posedge clock);

    for (int r = 0; r < 3; r++) foreach (fns[i]) random_r(fns[i]);
    report("r_type");

    for (int r = 0; r < 3; r++) foreach (ops[i]) random_i(ops[i]);
    report("immediate");

    for (int r = 0; r < 3; r++) foreach (ls_ops[i]) random_i(ls_ops[i]);
    report("load_store");

    issue(r_word(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU));
    issue(r_word(5'd3, 5'd3, 5'd4, 5'd0, FN_ADDU));  // both operands from EX
    ex_mem_dest <= 5'd7;
    ex_mem_dest_valid <= 1'b1;
    issue(r_word(5'd7, 5'd7, 5'd8, 5'd0, FN_ADDU));  // from MEM
    ex_mem_dest <= 5'd8;
    issue(r_word(5'd8, 5'd8, 5'd9, 5'd0, FN_ADDU));  // EX wins over MEM
    ex_mem_dest_valid <= 1'b0;
    issue(i_word(OPC_LW, 5'd1, 5'd11, 16'h0000));
    issue(i_word(OPC_SW, 5'd2, 5'd11, 16'h0004));  // late forward without a stall
    report("forwarding");

    issue(i_word(OPC_LW, 5'd1, 5'd12, 16'h0010));
    issue(r_word(5'd12, 5'd0, 5'd13, 5'd0, FN_ADDU));
    issue(i_word(OPC_LH, 5'd2, 5'd14, 16'h0020));
    issue(r_word(5'd3, 5'd14, 5'd15, 5'd0, FN_SUBU));  // B use also stalls
    report("load_use");

    wb_we <= 1'b1;
    wb_addr <= 5'd5;
    wb_data <= take_bits(32);
    issue('0);
    wb_we <= 1'b0;
    issue(r_word(5'd5, 5'd5, 5'd16, 5'd0, FN_OR));
    wb_we <= 1'b1;
    wb_addr <= 5'd6;
    wb_data <= take_bits(32);
    issue(r_word(5'd6, 5'd5, 5'd17, 5'd0, FN_OR));  // same-cycle bypass
    wb_addr <= 5'd0;
    wb_data <= take_bits(32);
    issue('0);
    wb_we <= 1'b0;
    issue(r_word(5'd0, 5'd6, 5'd18, 5'd0, FN_AND));
    report("reg_file");

    fails = UUT.u_chk.err_cnt;
    $display("tests 6, failures %0d", fails);
    if (fails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #200us;
    $display("run did not finish in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/decode_stage.sv
`default_nettype none

module decode_stage import mips_pkg::*; (
  input  logic      clock,
  input  logic      arst_n,
  input  word_t     pc,
  input  word_t     inst_word,
  input  reg_addr_t ex_mem_dest,
  input  logic      ex_mem_dest_valid,
  input  logic      wb_we,
  input  reg_addr_t wb_addr,
  input  word_t     wb_data,
  output id_ex_t    id_ex,
  output logic      stall
);

  dec_ctrl_t ctrl;
  word_t     rd_data1;
  word_t     rd_data2;
  fwd_t      a_fwd;
  fwd_t      b_fwd;

  inst_decode u_inst_decode (
    .inst_word (inst_word),
    .ctrl      (ctrl)
  );

  // read straight from rs/rt, ahead of the decode
  reg_file u_reg_file (
    .clock    (clock),
    .arst_n   (arst_n),
    .rd_addr1 (inst_word[25:21]),
    .rd_addr2 (inst_word[20:16]),
    .wr_en    (wb_we),
    .wr_addr  (wb_addr),
    .wr_data  (wb_data),
    .rd_data1 (rd_data1),
    .rd_data2 (rd_data2)
  );

  hazard_unit u_hazard_unit (
    .ctrl              (ctrl),
    .ex_stage          (id_ex),
    .ex_mem_dest       (ex_mem_dest),
    .ex_mem_dest_valid (ex_mem_dest_valid),
    .a_fwd             (a_fwd),
    .b_fwd             (b_fwd),
    .stall             (stall)
  );

  id_ex_reg u_id_ex_reg (
    .clock  (clock),
    .arst_n (arst_n),
    .stall  (stall),
    .pc     (pc),
    .a_data (rd_data1),
    .b_data (rd_data2),
    .a_fwd  (a_fwd),
    .b_fwd  (b_fwd),
    .ctrl   (ctrl),
    .id_ex  (id_ex)
  );

endmodule

`default_nettype wire

// File: rtl/hazard_unit.sv
`default_nettype none

module hazard_unit import mips_pkg::*; (
  input  dec_ctrl_t ctrl,
  input  id_ex_t    ex_stage,
  input  reg_addr_t ex_mem_dest,
  input  logic      ex_mem_dest_valid,
  output fwd_t      a_fwd,
  output fwd_t      b_fwd,
  output logic      stall
);

  logic a_match_ex;
  logic b_match_ex;
  logic a_match_mem;
  logic b_match_mem;
  logic ex_load;

  // EX is the instruction now in id_ex, MEM is the one after it
  assign a_match_ex = ctrl.a_valid && ex_stage.ctrl.dest_valid &&
                      (ctrl.a_reg == ex_stage.ctrl.dest_reg);
  assign b_match_ex = ctrl.b_valid && ex_stage.ctrl.dest_valid &&
                      (ctrl.b_reg == ex_stage.ctrl.dest_reg);

  assign a_match_mem = ctrl.a_valid && ex_mem_dest_valid && (ctrl.a_reg == ex_mem_dest);
  assign b_match_mem = ctrl.b_valid && ex_mem_dest_valid && (ctrl.b_reg == ex_mem_dest);

  assign ex_load = ex_stage.ctrl.load_inst;

  assign a_fwd = a_match_ex  ? FWD_EXMEM :
                 a_match_mem ? FWD_MEMWB : FWD_NONE;

  assign b_fwd = b_match_ex  ? (ex_load ? FWD_MEMWB_LATE : FWD_EXMEM) :
                 b_match_mem ? FWD_MEMWB : FWD_NONE;

  // load result not ready in time for EX
  assign stall = ex_load && (a_match_ex || (b_match_ex && !ctrl.b_need_late));

endmodule

`default_nettype wire

// File: rtl/id_ex_reg.sv
`default_nettype none

module id_ex_reg import mips_pkg::*; (
  input  logic      clock,
  input  logic      arst_n,
  input  logic      stall,
  input  word_t     pc,
  input  word_t     a_data,
  input  word_t     b_data,
  input  fwd_t      a_fwd,
  input  fwd_t      b_fwd,
  input  dec_ctrl_t ctrl,
  output id_ex_t    id_ex
);

  id_ex_t id_ex_nxt;

  always_comb begin
    id_ex_nxt.pc     = pc;
    id_ex_nxt.a_data = a_data;
    id_ex_nxt.b_data = b_data;
    id_ex_nxt.a_fwd  = a_fwd;
    id_ex_nxt.b_fwd  = b_fwd;
    id_ex_nxt.ctrl   = ctrl;
    if (stall) begin  // bubble, payload left as is
      id_ex_nxt.a_fwd            = FWD_NONE;
      id_ex_nxt.b_fwd            = FWD_NONE;
      id_ex_nxt.ctrl.a_valid     = 1'b0;
      id_ex_nxt.ctrl.b_valid     = 1'b0;
      id_ex_nxt.ctrl.b_need_late = 1'b0;
      id_ex_nxt.ctrl.dest_valid  = 1'b0;
      id_ex_nxt.ctrl.imm_valid   = 1'b0;
      id_ex_nxt.ctrl.alu_inst    = 1'b0;
      id_ex_nxt.ctrl.load_inst   = 1'b0;
      id_ex_nxt.ctrl.store_inst  = 1'b0;
      id_ex_nxt.ctrl.jmp_inst    = 1'b0;
      id_ex_nxt.ctrl.illegal     = 1'b0;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      id_ex <= '0;  // all-zero is a bubble
    end else begin
      id_ex <= id_ex_nxt;
    end
  end

endmodule

`default_nettype wire

// File: rtl/inst_decode.sv
`default_nettype none

module inst_decode import mips_pkg::*; (
  input  word_t     inst_word,
  output dec_ctrl_t ctrl
);

  logic [5:0]  opc;
  reg_addr_t   rs;
  reg_addr_t   rt;
  reg_addr_t   rd;
  shamt_t      sa;
  logic [5:0]  funct;
  logic [15:0] imm16;
  logic        imm_sext;

  assign opc   = inst_word[31:26];
  assign rs    = inst_word[25:21];
  assign rt    = inst_word[20:16];
  assign rd    = inst_word[15:11];
  assign sa    = inst_word[10:6];
  assign funct = inst_word[5:0];
  assign imm16 = inst_word[15:0];

  always_comb begin
    ctrl            = '0;
    ctrl.a_reg      = rs;
    ctrl.b_reg      = rt;
    ctrl.dest_reg   = rt;  // I-type writes rt
    ctrl.dest_valid = 1'b1;
    ctrl.imm_valid  = 1'b1;
    ctrl.alu_op     = OP_PASS_A;
    ctrl.res_sel    = RES_ALU;
    ctrl.ls_op      = LS_WORD;
    imm_sext        = 1'b0;

    case (opc)
      OPC_SPECIAL: begin
        ctrl.dest_reg  = rd;
        ctrl.imm_valid = 1'b0;
        ctrl.shamt     = sa;
        ctrl.alu_inst  = 1'b1;
        ctrl.a_valid   = 1'b1;
        ctrl.b_valid   = 1'b1;
        case (funct)
          FN_SLL: begin
            ctrl.alu_op  = OP_SLL;
            ctrl.a_valid = 1'b0;  // constant shift, rs unused
          end
          FN_SRL: begin
            ctrl.alu_op  = OP_SRL;
            ctrl.a_valid = 1'b0;
          end
          FN_SRA: begin
            ctrl.alu_op  = OP_SRA;
            ctrl.a_valid = 1'b0;
          end
          FN_SLLV:         ctrl.alu_op = OP_SLL;
          FN_SRLV:         ctrl.alu_op = OP_SRL;
          FN_SRAV:         ctrl.alu_op = OP_SRA;
          FN_JR, FN_JALR: begin
            ctrl.alu_inst   = 1'b0;
            ctrl.b_valid    = 1'b0;
            ctrl.jmp_inst   = 1'b1;
            ctrl.dest_valid = (funct == FN_JALR);  // jalr links to rd
          end
          FN_ADD, FN_ADDU: ctrl.alu_op = OP_ADD;
          FN_SUB, FN_SUBU: ctrl.alu_op = OP_SUB;
          FN_AND:          ctrl.alu_op = OP_AND;
          FN_OR:           ctrl.alu_op = OP_OR;
          FN_XOR:          ctrl.alu_op = OP_XOR;
          FN_NOR:          ctrl.alu_op = OP_NOR;
          FN_SLT, FN_SLTU: begin
            ctrl.alu_op    = OP_SUB;
            ctrl.res_sel   = RES_SET;
            ctrl.alu_set_u = (funct == FN_SLTU);
          end
          default:         ctrl.illegal = 1'b1;
        endcase
      end

      OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU: begin
        imm_sext      = 1'b1;
        ctrl.alu_inst = 1'b1;
        ctrl.a_valid  = 1'b1;
        if (opc == OPC_ADDI || opc == OPC_ADDIU) begin
          ctrl.alu_op = OP_ADD;
        end else begin
          ctrl.alu_op    = OP_SUB;
          ctrl.res_sel   = RES_SET;
          ctrl.alu_set_u = (opc == OPC_SLTIU);
        end
      end

      OPC_ANDI, OPC_ORI, OPC_XORI: begin
        ctrl.alu_inst = 1'b1;
        ctrl.a_valid  = 1'b1;
        ctrl.alu_op   = (opc == OPC_ANDI) ? OP_AND :
                        (opc == OPC_ORI)  ? OP_OR  : OP_XOR;
      end

      OPC_LUI: begin
        ctrl.alu_inst = 1'b1;
        ctrl.alu_op   = OP_LUI;
      end

      OPC_LB, OPC_LH, OPC_LW, OPC_LBU, OPC_LHU: begin
        imm_sext       = 1'b1;
        ctrl.alu_op    = OP_ADD;  // address calc
        ctrl.load_inst = 1'b1;
        ctrl.a_valid   = 1'b1;
        ctrl.ls_sext   = (opc == OPC_LB) || (opc == OPC_LH);
        ctrl.ls_op     = (opc == OPC_LW) ? LS_WORD :
                         (opc == OPC_LB || opc == OPC_LBU) ? LS_BYTE : LS_HALF;
      end

      OPC_SB, OPC_SH, OPC_SW: begin
        imm_sext         = 1'b1;
        ctrl.alu_op      = OP_ADD;
        ctrl.store_inst  = 1'b1;
        ctrl.a_valid     = 1'b1;
        ctrl.b_valid     = 1'b1;
        ctrl.b_need_late = 1'b1;  // store data goes straight to MEM
        ctrl.dest_valid  = 1'b0;
        ctrl.ls_op       = (opc == OPC_SW) ? LS_WORD :
                           (opc == OPC_SB) ? LS_BYTE : LS_HALF;
      end

      default: ctrl.illegal = 1'b1;
    endcase

    // unknown codes leave nothing for the pipeline to act on
    if (ctrl.illegal) begin
      ctrl.a_valid     = 1'b0;
      ctrl.b_valid     = 1'b0;
      ctrl.b_need_late = 1'b0;
      ctrl.dest_valid  = 1'b0;
      ctrl.imm_valid   = 1'b0;
      ctrl.alu_inst    = 1'b0;
      ctrl.load_inst   = 1'b0;
      ctrl.store_inst  = 1'b0;
      ctrl.jmp_inst    = 1'b0;
    end

    ctrl.imm = imm_sext ? {{16{imm16[15]}}, imm16} : {16'b0, imm16};
  end

endmodule

`default_nettype wire

// File: rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [4:0]  shamt_t;

  typedef enum logic [3:0] {
    OP_PASS_A,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_NOR,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_LUI
  } alu_op_t;

  typedef enum logic {
    RES_ALU,
    RES_SET  // set-less-than result
  } res_sel_t;

  typedef enum logic [1:0] {
    LS_WORD,
    LS_HALF,
    LS_BYTE
  } ls_op_t;

  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_EXMEM,
    FWD_MEMWB,
    FWD_MEMWB_LATE  // store data from a load, picked up at MEM
  } fwd_t;

  // primary opcodes
  localparam logic [5:0] OPC_SPECIAL = 6'h00;
  localparam logic [5:0] OPC_ADDI    = 6'h08;
  localparam logic [5:0] OPC_ADDIU   = 6'h09;
  localparam logic [5:0] OPC_SLTI    = 6'h0a;
  localparam logic [5:0] OPC_SLTIU   = 6'h0b;
  localparam logic [5:0] OPC_ANDI    = 6'h0c;
  localparam logic [5:0] OPC_ORI     = 6'h0d;
  localparam logic [5:0] OPC_XORI    = 6'h0e;
  localparam logic [5:0] OPC_LUI     = 6'h0f;
  localparam logic [5:0] OPC_LB      = 6'h20;
  localparam logic [5:0] OPC_LH      = 6'h21;
  localparam logic [5:0] OPC_LW      = 6'h23;
  localparam logic [5:0] OPC_LBU     = 6'h24;
  localparam logic [5:0] OPC_LHU     = 6'h25;
  localparam logic [5:0] OPC_SB      = 6'h28;
  localparam logic [5:0] OPC_SH      = 6'h29;
  localparam logic [5:0] OPC_SW      = 6'h2b;

  // funct codes under OPC_SPECIAL
  localparam logic [5:0] FN_SLL  = 6'h00;
  localparam logic [5:0] FN_SRL  = 6'h02;
  localparam logic [5:0] FN_SRA  = 6'h03;
  localparam logic [5:0] FN_SLLV = 6'h04;
  localparam logic [5:0] FN_SRLV = 6'h06;
  localparam logic [5:0] FN_SRAV = 6'h07;
  localparam logic [5:0] FN_JR   = 6'h08;
  localparam logic [5:0] FN_JALR = 6'h09;
  localparam logic [5:0] FN_ADD  = 6'h20;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUB  = 6'h22;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR  = 6'h26;
  localparam logic [5:0] FN_NOR  = 6'h27;
  localparam logic [5:0] FN_SLT  = 6'h2a;
  localparam logic [5:0] FN_SLTU = 6'h2b;

  typedef struct packed {
    reg_addr_t a_reg;
    logic      a_valid;
    reg_addr_t b_reg;
    logic      b_valid;
    logic      b_need_late;  // B only needed at MEM
    reg_addr_t dest_reg;
    logic      dest_valid;
    word_t     imm;
    logic      imm_valid;
    shamt_t    shamt;
    alu_op_t   alu_op;
    logic      alu_set_u;
    res_sel_t  res_sel;
    ls_op_t    ls_op;
    logic      ls_sext;
    logic      alu_inst;
    logic      load_inst;
    logic      store_inst;
    logic      jmp_inst;
    logic      illegal;
  } dec_ctrl_t;

  typedef struct packed {
    word_t     pc;
    word_t     a_data;
    word_t     b_data;
    fwd_t      a_fwd;
    fwd_t      b_fwd;
    dec_ctrl_t ctrl;
  } id_ex_t;

endpackage

`default_nettype wire

// File: rtl/reg_file.sv
`default_nettype none

module reg_file import mips_pkg::*; (
  input  logic      clock,
  input  logic      arst_n,
  input  reg_addr_t rd_addr1,
  input  reg_addr_t rd_addr2,
  input  logic      wr_en,
  input  reg_addr_t wr_addr,
  input  word_t     wr_data,
  output word_t     rd_data1,
  output word_t     rd_data2
);

  word_t regs [1:31];  // r0 is not stored

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  function automatic word_t read_port(reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (wr_en && wr_addr == addr) begin
      return wr_data;  // same-cycle write bypass
    end else begin
      return regs[addr];
    end
  endfunction

  always_comb begin
    rd_data1 = read_port(rd_addr1);
    rd_data2 = read_port(rd_addr2);
  end

endmodule

`default_nettype wire
